//--- flist.f
source/coco_pkg.sv
source/option_decode.sv
source/joy_route.sv
source/tape_buffer.sv
source/tape_player.sv
source/coco_glue_top.sv
sim/tb_coco_glue.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the CoCo3 glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_coco_glue -o sim_coco_glue

sim_out=$(./obj_dir/sim_coco_glue)
echo "$sim_out"

if grep -qF "** PASS **" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi

//--- sim/tb_coco_glue.sv
/* CoCo3 glue testbench */

`timescale 1ns/100ps

module tb_coco_glue;

	import coco_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 8;
	localparam int N_RANDOM     = 16;
	localparam int N_BYTES      = 6;
	// Cycles between tape ticks, covers the fetch and the audio register
	localparam int TICK_GAP     = 6;
	// Reset, option and joystick tests, then download and two tape passes
	localparam int TEST_CYCLES  = RESET_CYCLES + 60 + 2 * N_RANDOM * 4 + 4 * N_BYTES + 20
		+ (N_BYTES + 4) * (BYTE_W + 1) * (TICK_GAP + 1);

	logic                 clk_sys;
	logic                 rst;
	logic [STATUS_W-1:0]  status;
	logic                 user_button;
	logic [JOY_W-1:0]     joy1_in;
	logic [JOY_W-1:0]     joy2_in;
	logic [AJOY_W-1:0]    ajoy1_in;
	logic [AJOY_W-1:0]    ajoy2_in;
	logic                 dl_active;
	logic                 dl_wr;
	logic [BYTE_W-1:0]    dl_index;
	logic [DL_ADDR_W-1:0] dl_addr;
	logic [BYTE_W-1:0]    dl_data;
	logic                 tape_tick;
	logic                 motor_on;
	logic [AUDIO_W-1:0]   audio_in;
	logic                 core_reset;
	logic                 config_reset;
	mpi_slot_e            mpi_slot;
	mem_size_e            mem_size;
	turbo_e               turbo;
	logic [JOY_W-1:0]     joy1;
	logic [JOY_W-1:0]     joy2;
	logic [AJOY_W-1:0]    ajoy1;
	logic [AJOY_W-1:0]    ajoy2;
	logic                 tape_bit;
	logic [AUDIO_W-1:0]   audio_out;

	// Result counters, test_err marks the start of the running test
	int check_count = 0;
	int err_count   = 0;
	int test_err    = 0;
	// Cassette image as downloaded, and the playback position
	logic [BYTE_W-1:0] image [N_BYTES];
	int                byte_pos = 0;
	int                bit_pos  = 0;
	logic              last_bit = 1'b0;

	coco_glue_top i_dut (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ======================================================================
	// Reference model
	// ======================================================================
	// Slot is the menu value plus one, wrapping at four
	function automatic void expect_options(input logic [STATUS_W-1:0] word,
		output mpi_slot_e slot, output mem_size_e mem, output turbo_e speed);
		slot  = mpi_slot_e'((int'(word[ST_MPI_LO +: 2]) + 1) % 4);
		mem   = mem_size_e'(word[ST_MEM_LO +: 3]);
		speed = turbo_e'(word[ST_TURBO_LO +: 3]);
	endfunction

	// Port 1 gets the other stick when swapped
	function automatic logic [JOY_W-1:0] route_joy(input logic swap, input int port,
		input logic [JOY_W-1:0] first, input logic [JOY_W-1:0] second);
		return ((port == 1) ^ swap) ? first : second;
	endfunction

	// Each axis byte moves up by half scale
	function automatic logic [AJOY_W-1:0] center_ref(input logic [AJOY_W-1:0] raw);
		int x_axis;
		int y_axis;
		x_axis = (int'(raw[15:8]) + 128) % 256;
		y_axis = (int'(raw[7:0]) + 128) % 256;
		return {x_axis[7:0], y_axis[7:0]};
	endfunction

	// MSB first out of each stored byte
	function automatic logic tape_bit_ref(input int byte_idx, input int bit_idx);
		return image[byte_idx][BYTE_W-1-bit_idx];
	endfunction

	function automatic logic [AUDIO_W-1:0] audio_ref(input logic [AUDIO_W-1:0] sample,
		input logic bit_val, input logic monitor);
		audio_ref = sample;
		if (monitor && bit_val)
			audio_ref[AUDIO_TAPE_BIT] = ~sample[AUDIO_TAPE_BIT];
	endfunction

	// ======================================================================
	// Compare tasks
	// ======================================================================
	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		check_count++;
		if (got !== exp)
		begin
			err_count++;
			$display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_slot(input mpi_slot_e got, input mpi_slot_e exp);
		compare_value("mpi_slot", 64'(got), 64'(exp));
	endtask

	task automatic check_mem(input mem_size_e got, input mem_size_e exp);
		compare_value("mem_size", 64'(got), 64'(exp));
	endtask

	task automatic check_turbo(input turbo_e got, input turbo_e exp);
		compare_value("turbo", 64'(got), 64'(exp));
	endtask

	task automatic check_joy(input string name, input logic [JOY_W-1:0] got,
		input logic [JOY_W-1:0] exp);
		compare_value(name, 64'(got), 64'(exp));
	endtask

	task automatic check_ajoy(input string name, input logic [AJOY_W-1:0] got,
		input logic [AJOY_W-1:0] exp);
		compare_value(name, 64'(got), 64'(exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		compare_value(name, 64'(got), 64'(exp));
	endtask

	task automatic check_audio(input logic [AUDIO_W-1:0] got, input logic [AUDIO_W-1:0] exp);
		compare_value("audio_out", 64'(got), 64'(exp));
	endtask

	task automatic end_test(input string name);
		$display("Test %s done, %0d errors", name, err_count - test_err);
		test_err = err_count;
	endtask

	// ======================================================================
	// Stimulus helpers
	// ======================================================================
	// Pulse lands two cycles after the field change, or not at all
	task automatic watch_config(input logic [STATUS_W-1:0] word, input logic pulse);
		@(posedge clk_sys);
		status <= word;
		for (int i = 0; i < 6; i++)
		begin
			@(negedge clk_sys);
			check_bit("config_reset", config_reset, pulse && (i == 2));
		end
	endtask

	// One cycle of the source gives one cycle of core reset
	task automatic check_reset_source(input logic use_button);
		@(posedge clk_sys);
		if (use_button)
			user_button <= 1'b1;
		else
			status[ST_RESET] <= 1'b1;
		@(posedge clk_sys);
		user_button      <= 1'b0;
		status[ST_RESET] <= 1'b0;
		@(negedge clk_sys);
		check_bit("core_reset", core_reset, 1'b1);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_bit("core_reset", core_reset, 1'b0);
	endtask

	// Cassette bytes interleaved with strobes for another image
	task automatic download_image();
		@(posedge clk_sys);
		dl_active <= 1'b1;
		for (int a = 0; a < N_BYTES; a++)
		begin
			image[a] = BYTE_W'($urandom);
			@(posedge clk_sys);
			dl_wr    <= 1'b1;
			dl_index <= BYTE_W'(TAPE_INDEX);
			dl_addr  <= DL_ADDR_W'(a);
			dl_data  <= image[a];
			@(posedge clk_sys);
			dl_index <= BYTE_W'(1);
			dl_data  <= ~image[a];
		end
		@(posedge clk_sys);
		dl_wr     <= 1'b0;
		dl_active <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	// One tick, then settle before sampling
	task automatic tick_once();
		@(posedge clk_sys);
		tape_tick <= 1'b1;
		@(posedge clk_sys);
		tape_tick <= 1'b0;
		repeat (TICK_GAP - 1) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic play_bits(input int count);
		logic exp_bit;
		for (int k = 0; k < count; k++)
		begin
			// First tick of a byte only starts the fetch
			if (bit_pos == 0)
				tick_once();
			tick_once();
			exp_bit = tape_bit_ref(byte_pos, bit_pos);
			last_bit = exp_bit;
			check_bit("tape_bit", tape_bit, exp_bit);
			check_audio(audio_out, audio_ref(audio_in, exp_bit, 1'b1));
			bit_pos++;
			if (bit_pos == BYTE_W)
			begin
				bit_pos = 0;
				byte_pos++;
			end
		end
	endtask

	task automatic pulse_rewind();
		@(posedge clk_sys);
		status[ST_REWIND] <= 1'b1;
		repeat (3) @(posedge clk_sys);
		status[ST_REWIND] <= 1'b0;
		repeat (3) @(posedge clk_sys);
		byte_pos = 0;
		bit_pos  = 0;
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================
	initial
	begin
		logic [STATUS_W-1:0] word;
		mpi_slot_e           exp_slot;
		mem_size_e           exp_mem;
		turbo_e              exp_turbo;
		logic                swap;

		void'($urandom(15126));
		rst         = 1'b1;
		status      = '0;
		user_button = 1'b0;
		joy1_in     = '0;
		joy2_in     = '0;
		ajoy1_in    = '0;
		ajoy2_in    = '0;
		dl_active   = 1'b0;
		dl_wr       = 1'b0;
		dl_index    = '0;
		dl_addr     = '0;
		dl_data     = '0;
		tape_tick   = 1'b0;
		motor_on    = 1'b0;
		audio_in    = '0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		rst <= 1'b0;
		@(negedge clk_sys);
		check_bit("core_reset", core_reset, 1'b1);
		check_bit("tape_bit", tape_bit, 1'b0);

		// Menu load is the first change, then real changes pulse
		word = '0;
		word[ST_MPI_LO +: 2] = 2'd1;
		watch_config(word, 1'b0);
		word[ST_MEM_LO +: 3] = 3'd2;
		watch_config(word, 1'b1);
		word[ST_MPI_LO +: 2] = 2'd3;
		watch_config(word, 1'b1);
		check_reset_source(1'b0);
		check_reset_source(1'b1);
		end_test("config_reset");

		for (int n = 0; n < N_RANDOM; n++)
		begin
			word = {$urandom, $urandom};
			@(posedge clk_sys);
			status <= word;
			@(posedge clk_sys);
			@(negedge clk_sys);
			expect_options(word, exp_slot, exp_mem, exp_turbo);
			check_slot(mpi_slot, exp_slot);
			check_mem(mem_size, exp_mem);
			check_turbo(turbo, exp_turbo);
		end
		end_test("options");

		for (int s = 0; s < 2; s++)
		begin
			swap = (s == 1);
			@(posedge clk_sys);
			status <= 64'(swap) << ST_SWAP_JOY;
			repeat (2) @(posedge clk_sys);
			for (int n = 0; n < N_RANDOM; n++)
			begin
				@(posedge clk_sys);
				joy1_in  <= $urandom;
				joy2_in  <= $urandom;
				ajoy1_in <= AJOY_W'($urandom);
				ajoy2_in <= AJOY_W'($urandom);
				@(posedge clk_sys);
				@(negedge clk_sys);
				check_joy("joy1", joy1, route_joy(swap, 1, joy1_in, joy2_in));
				check_joy("joy2", joy2, route_joy(swap, 2, joy1_in, joy2_in));
				check_ajoy("ajoy1", ajoy1, center_ref(swap ? ajoy2_in : ajoy1_in));
				check_ajoy("ajoy2", ajoy2, center_ref(swap ? ajoy1_in : ajoy2_in));
			end
		end
		end_test("joystick");

		// Monitor on, silent input so bit 13 carries the tape alone
		@(posedge clk_sys);
		status   <= 64'(1) << ST_TAPE_MON;
		audio_in <= '0;
		download_image();
		@(posedge clk_sys);
		motor_on <= 1'b1;
		play_bits(N_BYTES * BYTE_W);
		end_test("tape_play");

		pulse_rewind();
		play_bits(BYTE_W + 3);
		pulse_rewind();
		play_bits(2 * BYTE_W);
		end_test("rewind");

		@(posedge clk_sys);
		status <= '0;
		for (int n = 0; n < N_RANDOM; n++)
		begin
			@(posedge clk_sys);
			audio_in <= AUDIO_W'($urandom);
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_audio(audio_out, audio_ref(audio_in, last_bit, 1'b0));
		end
		end_test("audio_pass");

		$display("Checks %0d, errors %0d", check_count, err_count);
		if (err_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (20 * TEST_CYCLES) @(posedge clk_sys);
		$display("Timeout, tests did not finish within %0d cycles", 20 * TEST_CYCLES);
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- source/coco_glue_top.sv
/* CoCo3 host glue top level */

`timescale 1ns/100ps

module coco_glue_top #(
	parameter int TAPE_ADDR_W = coco_pkg::TAPE_ADDR_W_DEF
) (
	input  logic                           clk_sys,
	input  logic                           rst,
	// Host menu
	input  logic [coco_pkg::STATUS_W-1:0]  status,
	input  logic                           user_button,
	// Host joysticks
	input  logic [coco_pkg::JOY_W-1:0]     joy1_in,
	input  logic [coco_pkg::JOY_W-1:0]     joy2_in,
	input  logic [coco_pkg::AJOY_W-1:0]    ajoy1_in,
	input  logic [coco_pkg::AJOY_W-1:0]    ajoy2_in,
	// Host download stream
	input  logic                           dl_active,
	input  logic                           dl_wr,
	input  logic [coco_pkg::BYTE_W-1:0]    dl_index,
	input  logic [coco_pkg::DL_ADDR_W-1:0] dl_addr,
	input  logic [coco_pkg::BYTE_W-1:0]    dl_data,
	// Cassette timing from the core
	input  logic                           tape_tick,
	input  logic                           motor_on,
	input  logic [coco_pkg::AUDIO_W-1:0]   audio_in,
	// Core side
	output logic                           core_reset,
	output logic                           config_reset,
	output coco_pkg::mpi_slot_e            mpi_slot,
	output coco_pkg::mem_size_e            mem_size,
	output coco_pkg::turbo_e               turbo,
	output logic [coco_pkg::JOY_W-1:0]     joy1,
	output logic [coco_pkg::JOY_W-1:0]     joy2,
	output logic [coco_pkg::AJOY_W-1:0]    ajoy1,
	output logic [coco_pkg::AJOY_W-1:0]    ajoy2,
	output logic                           tape_bit,
	output logic [coco_pkg::AUDIO_W-1:0]   audio_out
);

	import coco_pkg::*;

	// Option fields routed to the other stages
	logic swap_joy;
	logic tape_rewind;
	logic tape_monitor;

	// Tape RAM read port and load flag
	logic [TAPE_ADDR_W-1:0] rd_addr;
	logic [BYTE_W-1:0]      rd_data;
	logic                   tape_loading;

	// ======================================================================
	// Status decode and reset generation
	// ======================================================================
	option_decode i_option_decode (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.status       (status),
		.user_button  (user_button),
		.core_reset   (core_reset),
		.config_reset (config_reset),
		.mpi_slot     (mpi_slot),
		.mem_size     (mem_size),
		.turbo        (turbo),
		.swap_joy     (swap_joy),
		.tape_rewind  (tape_rewind),
		.tape_monitor (tape_monitor)
	);

	// Joystick swap and centering
	joy_route i_joy_route (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.swap_joy (swap_joy),
		.joy1_in  (joy1_in),
		.joy2_in  (joy2_in),
		.ajoy1_in (ajoy1_in),
		.ajoy2_in (ajoy2_in),
		.joy1     (joy1),
		.joy2     (joy2),
		.ajoy1    (ajoy1),
		.ajoy2    (ajoy2)
	);

	// ======================================================================
	// Cassette path, download into RAM then playback
	// ======================================================================
	tape_buffer #(
		.TAPE_ADDR_W (TAPE_ADDR_W)
	) i_tape_buffer (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_index     (dl_index),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.tape_loading (tape_loading)
	);

	tape_player #(
		.TAPE_ADDR_W (TAPE_ADDR_W)
	) i_tape_player (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.tape_loading (tape_loading),
		.tape_rewind  (tape_rewind),
		.motor_on     (motor_on),
		.tape_tick    (tape_tick),
		.tape_monitor (tape_monitor),
		.rd_data      (rd_data),
		.audio_in     (audio_in),
		.rd_addr      (rd_addr),
		.tape_bit     (tape_bit),
		.audio_out    (audio_out)
	);

endmodule

//--- source/coco_pkg.sv
/* CoCo3 glue shared definitions */

package coco_pkg;

	// ======================================================================
	// Bus and sample widths
	// ======================================================================
	localparam int STATUS_W        = 64;
	localparam int AUDIO_W         = 16;
	localparam int BYTE_W          = 8;
	localparam int DL_ADDR_W       = 25;
	localparam int TAPE_ADDR_W_DEF = 16;
	localparam int JOY_W           = 32;
	// X axis in the high byte, Y axis in the low byte
	localparam int AJOY_W          = 16;

	// ======================================================================
	// Host status word bit map
	// ======================================================================
	localparam int ST_RESET    = 0;
	localparam int ST_SWAP_JOY = 6;
	// Multi-pak slot, 2 bits
	localparam int ST_MPI_LO   = 12;
	localparam int ST_REWIND   = 15;
	localparam int ST_TAPE_MON = 17;
	// Memory size, 3 bits
	localparam int ST_MEM_LO   = 25;
	// Turbo speed, 3 bits, upper half of the word
	localparam int ST_TURBO_LO = 32;

	// Download index of a cassette image
	localparam int TAPE_INDEX     = 2;
	// Audio bit flipped by the tape signal
	localparam int AUDIO_TAPE_BIT = 13;

	// ======================================================================
	// Option and state encodings
	// ======================================================================
	// Menu value plus one, wraps at four
	typedef enum logic [1:0] {
		SLOT_1,
		SLOT_2,
		SLOT_3,
		SLOT_4
	} mpi_slot_e;

	// Codes 4 to 7 are not named but still carried
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_16M  = 3'd3
	} mem_size_e;

	typedef enum logic [2:0] {
		TURBO_COCO,
		TURBO_089,
		TURBO_178,
		TURBO_286,
		TURBO_358,
		TURBO_716,
		TURBO_954
	} turbo_e;

	typedef enum logic [1:0] {
		TAPE_IDLE,
		TAPE_FETCH,
		TAPE_SHIFT
	} tape_state_e;

endpackage

//--- source/joy_route.sv
/* Joystick swap and centering */

`timescale 1ns/100ps

module joy_route (
	input  logic                        clk_sys,
	input  logic                        rst,
	input  logic                        swap_joy,
	input  logic [coco_pkg::JOY_W-1:0]  joy1_in,
	input  logic [coco_pkg::JOY_W-1:0]  joy2_in,
	input  logic [coco_pkg::AJOY_W-1:0] ajoy1_in,
	input  logic [coco_pkg::AJOY_W-1:0] ajoy2_in,
	output logic [coco_pkg::JOY_W-1:0]  joy1,
	output logic [coco_pkg::JOY_W-1:0]  joy2,
	output logic [coco_pkg::AJOY_W-1:0] ajoy1,
	output logic [coco_pkg::AJOY_W-1:0] ajoy2
);

	import coco_pkg::*;

	// Signed host axis to unsigned, 0 lands on mid scale
	function automatic logic [AJOY_W-1:0] center_axes(input logic [AJOY_W-1:0] raw);
		logic [BYTE_W-1:0] x_axis;
		logic [BYTE_W-1:0] y_axis;
		x_axis = raw[AJOY_W-1 -: BYTE_W] + BYTE_W'(128);
		y_axis = raw[BYTE_W-1:0] + BYTE_W'(128);
		return {x_axis, y_axis};
	endfunction

	// ======================================================================
	// Port swap, then register
	// ======================================================================
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			joy1  <= '0;
			joy2  <= '0;
			ajoy1 <= '0;
			ajoy2 <= '0;
		end
		else
		begin
			// Digital and analog swap together
			joy1  <= swap_joy ? joy2_in : joy1_in;
			joy2  <= swap_joy ? joy1_in : joy2_in;
			ajoy1 <= center_axes(swap_joy ? ajoy2_in : ajoy1_in);
			ajoy2 <= center_axes(swap_joy ? ajoy1_in : ajoy2_in);
		end
	end

endmodule

//--- source/option_decode.sv
/* Host status option decode */

`timescale 1ns/100ps

module option_decode (
	input  logic                          clk_sys,
	input  logic                          rst,
	input  logic [coco_pkg::STATUS_W-1:0] status,
	input  logic                          user_button,
	output logic                          core_reset,
	output logic                          config_reset,
	output coco_pkg::mpi_slot_e           mpi_slot,
	output coco_pkg::mem_size_e           mem_size,
	output coco_pkg::turbo_e              turbo,
	output logic                          swap_joy,
	output logic                          tape_rewind,
	output logic                          tape_monitor
);

	import coco_pkg::*;

	localparam int SLOT_W  = $bits(mpi_slot_e);
	localparam int MEM_W   = $bits(mem_size_e);
	localparam int TURBO_W = $bits(turbo_e);

	// Raw menu slot value, before the plus one offset
	logic [SLOT_W-1:0] slot_q;
	// One cycle older copies for change detection
	logic [SLOT_W-1:0] slot_d;
	mem_size_e         mem_d;
	// Set once the menu has loaded its initial settings
	logic              change_seen;
	logic              field_change;

	// Either the slot or the memory field moved last cycle
	assign field_change = (slot_q != slot_d) || (mem_size != mem_d);

	// ======================================================================
	// Status fields, registered into typed outputs
	// ======================================================================
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			mpi_slot     <= SLOT_1;
			mem_size     <= MEM_512K;
			turbo        <= TURBO_COCO;
			swap_joy     <= 1'b0;
			tape_rewind  <= 1'b0;
			tape_monitor <= 1'b0;
			slot_q       <= '0;
		end
		else
		begin
			// Slot number wraps, menu 3 selects slot 1
			mpi_slot     <= mpi_slot_e'(status[ST_MPI_LO +: SLOT_W] + SLOT_W'(1));
			// Unnamed memory codes go through as they are
			mem_size     <= mem_size_e'(status[ST_MEM_LO +: MEM_W]);
			turbo        <= turbo_e'(status[ST_TURBO_LO +: TURBO_W]);
			swap_joy     <= status[ST_SWAP_JOY];
			tape_rewind  <= status[ST_REWIND];
			tape_monitor <= status[ST_TAPE_MON];
			slot_q       <= status[ST_MPI_LO +: SLOT_W];
		end
	end

	// ======================================================================
	// Configuration change reset
	// ======================================================================
	// First change after reset is the menu load and gives no pulse
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			slot_d       <= '0;
			mem_d        <= MEM_512K;
			change_seen  <= 1'b0;
			config_reset <= 1'b0;
		end
		else
		begin
			slot_d       <= slot_q;
			mem_d        <= mem_size;
			// Single cycle pulse, field compare is clean the cycle after
			config_reset <= field_change & change_seen;
			if (field_change)
				change_seen <= 1'b1;
		end
	end

	// Core reset sources, merged and registered
	always_ff @(posedge clk_sys)
	begin
		core_reset <= rst | status[ST_RESET] | user_button;
	end

endmodule

//--- source/tape_buffer.sv
/* Cassette image RAM */

`timescale 1ns/100ps

module tape_buffer #(
	parameter int TAPE_ADDR_W = coco_pkg::TAPE_ADDR_W_DEF
) (
	input  logic                           clk_sys,
	input  logic                           rst,
	// Host download stream
	input  logic                           dl_active,
	input  logic                           dl_wr,
	input  logic [coco_pkg::BYTE_W-1:0]    dl_index,
	input  logic [coco_pkg::DL_ADDR_W-1:0] dl_addr,
	input  logic [coco_pkg::BYTE_W-1:0]    dl_data,
	// Player read port
	input  logic [TAPE_ADDR_W-1:0]         rd_addr,
	output logic [coco_pkg::BYTE_W-1:0]    rd_data,
	output logic                           tape_loading
);

	import coco_pkg::*;

	localparam int DEPTH = 2 ** TAPE_ADDR_W;

	// Cassette image storage
	logic [BYTE_W-1:0] tape_mem [DEPTH];
	// Strobe carries a cassette byte
	logic              tape_wr;

	// Other indices are disk or cartridge images, not for us
	assign tape_wr = dl_wr && dl_active && (dl_index == BYTE_W'(TAPE_INDEX));

	// ======================================================================
	// Write port, download side
	// ======================================================================
	// Only the low address bits are kept, the image wraps above that
	always_ff @(posedge clk_sys)
	begin
		if (tape_wr)
			tape_mem[dl_addr[TAPE_ADDR_W-1:0]] <= dl_data;
	end

	// Read port, data one cycle after the address
	always_ff @(posedge clk_sys)
	begin
		rd_data <= tape_mem[rd_addr];
	end

	// Player is held at the start while a download runs
	always_ff @(posedge clk_sys)
	begin
		if (rst)
			tape_loading <= 1'b0;
		else
			tape_loading <= dl_active;
	end

endmodule

//--- source/tape_player.sv
/* Cassette playback and audio mix */

`timescale 1ns/100ps

module tape_player #(
	parameter int TAPE_ADDR_W = coco_pkg::TAPE_ADDR_W_DEF
) (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  logic                         tape_loading,
	input  logic                         tape_rewind,
	input  logic                         motor_on,
	input  logic                         tape_tick,
	input  logic                         tape_monitor,
	input  logic [coco_pkg::BYTE_W-1:0]  rd_data,
	input  logic [coco_pkg::AUDIO_W-1:0] audio_in,
	output logic [TAPE_ADDR_W-1:0]       rd_addr,
	output logic                         tape_bit,
	output logic [coco_pkg::AUDIO_W-1:0] audio_out
);

	import coco_pkg::*;

	localparam int CNT_W = $clog2(BYTE_W);

	tape_state_e            state;
	// Byte position in the image
	logic [TAPE_ADDR_W-1:0] tape_addr;
	// Bits already sent from the current byte
	logic [CNT_W-1:0]       bit_cnt;
	logic [BYTE_W-1:0]      shift_reg;
	// Second cycle of a fetch, RAM data valid
	logic                   fetch_ph;
	// Ticks count only while the relay is closed
	logic                   tick_en;
	logic [AUDIO_W-1:0]     audio_mix;

	assign tick_en = tape_tick & motor_on;
	assign rd_addr = tape_addr;

	// ======================================================================
	// Byte fetch and bit serializer
	// ======================================================================
	always_ff @(posedge clk_sys)
	begin
		if (rst)
		begin
			state     <= TAPE_IDLE;
			tape_addr <= '0;
			bit_cnt   <= '0;
			shift_reg <= '0;
			fetch_ph  <= 1'b0;
			tape_bit  <= 1'b0;
		end
		else if (tape_rewind || tape_loading)
		begin
			// Back to the first byte, next tick fetches it
			state     <= TAPE_IDLE;
			tape_addr <= '0;
			bit_cnt   <= '0;
			fetch_ph  <= 1'b0;
		end
		else
		begin
			case (state)
				TAPE_IDLE:
				begin
					if (tick_en)
						state <= TAPE_FETCH;
				end
				TAPE_FETCH:
				begin
					// Address settles, then the byte is taken
					fetch_ph <= ~fetch_ph;
					if (fetch_ph)
					begin
						shift_reg <= rd_data;
						bit_cnt   <= '0;
						state     <= TAPE_SHIFT;
					end
				end
				TAPE_SHIFT:
				begin
					if (tick_en)
					begin
						// MSB first
						tape_bit  <= shift_reg[BYTE_W-1];
						shift_reg <= {shift_reg[BYTE_W-2:0], 1'b0};
						bit_cnt   <= bit_cnt + 1'b1;
						if (bit_cnt == CNT_W'(BYTE_W - 1))
						begin
							tape_addr <= tape_addr + 1'b1;
							state     <= TAPE_IDLE;
						end
					end
				end
				default:
					state <= TAPE_IDLE;
			endcase
		end
	end

	// ======================================================================
	// Tape monitor on the left channel
	// ======================================================================
	always_comb
	begin
		audio_mix = audio_in;
		audio_mix[AUDIO_TAPE_BIT] = audio_in[AUDIO_TAPE_BIT] ^ (tape_bit & tape_monitor);
	end

	always_ff @(posedge clk_sys)
	begin
		if (rst)
			audio_out <= '0;
		else
			audio_out <= audio_mix;
	end

endmodule
